// ==== kt_access_check.sv ====
/*
 * KT-11 access check: decodes the PDR access-control field and the page
 * length, giving abort, trap, page-bit update and fault record requests
 */
`timescale 1ns/100ps

module kt_access_check
(
   input  logic [15:0] cpu_va,
   input  logic [1:0]  cpu_mode,
   input  logic        cpu_rd,
   input  logic        cpu_wr,
   input  logic        trap_odd,
   input  logic        mmu_on,
   input  logic [15:0] pdr_value,
   output logic        signal_abort,
   output logic        signal_trap,
   output logic        update_pdr,
   output logic        set_a,
   output logic        set_w,
   output logic        fault_nonres,
   output logic        fault_ple,
   output logic        fault_ro,
   output logic        record_page
);

   logic [6:0] block_num;
   logic [6:0] page_len;
   logic [2:0] acf;
   logic       expand_down;
   logic       pg_len_err;

   assign block_num   = cpu_va[12:6];
   assign page_len    = pdr_value[kt_mmu_pkg::pdr_plf_hi:kt_mmu_pkg::pdr_plf_lo];
   assign acf         = pdr_value[2:0];
   assign expand_down = pdr_value[kt_mmu_pkg::pdr_ed_bit];

   // downward pages are valid from the length up to the top
   assign pg_len_err = expand_down ? (block_num < page_len) : (block_num > page_len);

   always_comb
   begin
      signal_abort = 1'b0;
      signal_trap  = 1'b0;
      update_pdr   = 1'b0;
      set_a        = 1'b0;
      set_w        = 1'b0;
      fault_nonres = 1'b0;
      fault_ple    = 1'b0;
      fault_ro     = 1'b0;
      record_page  = 1'b0;

      if (mmu_on && (cpu_rd || cpu_wr))
      begin
         // no supervisor space on the 11/34
         if (cpu_mode == kt_mmu_pkg::mode_super)
         begin
            fault_nonres = 1'b1;
            record_page  = 1'b1;
            signal_abort = 1'b1;
         end
         else
         begin
            case (acf)
               kt_mmu_pkg::acf_nonres, kt_mmu_pkg::acf_unused3, kt_mmu_pkg::acf_unused7:
               begin
                  update_pdr   = cpu_wr;
                  record_page  = 1'b1;
                  fault_nonres = 1'b1;
                  fault_ple    = pg_len_err;
                  signal_abort = 1'b1;
               end
               kt_mmu_pkg::acf_ro_trap, kt_mmu_pkg::acf_ro:
               begin
                  // reads of code 2 still check the length
                  if (cpu_wr)
                  begin
                     update_pdr   = 1'b1;
                     record_page  = 1'b1;
                     fault_ro     = 1'b1;
                     fault_ple    = pg_len_err;
                     signal_abort = 1'b1;
                  end
                  else if (acf == kt_mmu_pkg::acf_ro)
                  begin
                     record_page  = 1'b1;
                     fault_ple    = pg_len_err;
                     signal_abort = pg_len_err;
                  end
               end
               kt_mmu_pkg::acf_rw_trap:
               begin
                  // 11/34 flags this as non-resident and traps
                  update_pdr   = 1'b1;
                  set_a        = 1'b1;
                  record_page  = 1'b1;
                  fault_nonres = 1'b1;
                  signal_trap  = 1'b1;
               end
               kt_mmu_pkg::acf_rw_trap_wr:
               begin
                  // writes pass untouched on the 11/34
                  if (cpu_rd && !cpu_wr)
                  begin
                     record_page  = 1'b1;
                     fault_ple    = pg_len_err;
                     signal_abort = pg_len_err;
                  end
               end
               default:
               begin
                  // acf_rw
                  record_page = 1'b1;
                  fault_ple   = pg_len_err;
                  if (cpu_wr)
                  begin
                     update_pdr  = 1'b1;
                     set_w       = ~trap_odd;
                     signal_trap = pg_len_err;
                  end
                  else
                     signal_abort = pg_len_err;
               end
            endcase
         end
      end
   end

endmodule

// ==== kt_mmu.sv ====
/*
 * KT-11 memory management unit in its 11/34 variant, wiring the page
 * registers, access check, status registers and relocation
 */
`timescale 1ns/100ps

module kt_mmu
(
   input  logic        clk,
   input  logic        local_reset,
   input  logic [15:0] cpu_va,
   input  logic [1:0]  cpu_mode,
   input  logic        cpu_rd,
   input  logic        cpu_wr,
   input  logic        cpu_i_access,
   input  logic        cpu_d_access,
   input  logic        cpu_trap,
   input  logic        fetch_va,
   input  logic        trap_odd,
   output logic [21:0] cpu_pa,
   output logic        signal_abort,
   output logic        signal_trap,
   input  logic        reg_wr,
   input  logic        reg_rd,
   input  logic [1:0]  reg_be,
   input  logic [7:0]  reg_addr,
   input  logic [15:0] reg_wdata,
   output logic [15:0] reg_rdata
);

   logic        mmu_on;
   logic        map_enable;
   logic        d_space_enable;
   logic        fault_frozen;
   logic [15:0] pdr_value;
   logic [15:0] par_value;
   logic [15:0] reg_pdr_rdata;
   logic [15:0] reg_par_rdata;
   logic [15:0] reg_mmr_rdata;
   logic        update_pdr;
   logic        set_a;
   logic        set_w;
   logic        fault_nonres;
   logic        fault_ple;
   logic        fault_ro;
   logic        record_page;

   kt_status_regs u_status_regs (
      .clk            (clk),
      .local_reset    (local_reset),
      .reg_wr         (reg_wr),
      .reg_be         (reg_be),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .cpu_va         (cpu_va),
      .cpu_mode       (cpu_mode),
      .cpu_d_access   (cpu_d_access),
      .fetch_va       (fetch_va),
      .fault_nonres   (fault_nonres),
      .fault_ple      (fault_ple),
      .fault_ro       (fault_ro),
      .record_page    (record_page),
      .mmu_on         (mmu_on),
      .map_enable     (map_enable),
      .d_space_enable (d_space_enable),
      .fault_frozen   (fault_frozen),
      .reg_mmr_rdata  (reg_mmr_rdata)
   );

   kt_page_regs u_page_regs (
      .clk            (clk),
      .cpu_mode       (cpu_mode),
      .cpu_trap       (cpu_trap),
      .cpu_i_access   (cpu_i_access),
      .d_space_enable (d_space_enable),
      .cpu_page       (cpu_va[15:13]),
      .reg_wr         (reg_wr),
      .reg_be         (reg_be),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .update_pdr     (update_pdr),
      .set_a          (set_a),
      .set_w          (set_w),
      .pdr_value      (pdr_value),
      .par_value      (par_value),
      .reg_pdr_rdata  (reg_pdr_rdata),
      .reg_par_rdata  (reg_par_rdata)
   );

   kt_access_check u_access_check (
      .cpu_va       (cpu_va),
      .cpu_mode     (cpu_mode),
      .cpu_rd       (cpu_rd),
      .cpu_wr       (cpu_wr),
      .trap_odd     (trap_odd),
      .mmu_on       (mmu_on),
      .pdr_value    (pdr_value),
      .signal_abort (signal_abort),
      .signal_trap  (signal_trap),
      .update_pdr   (update_pdr),
      .set_a        (set_a),
      .set_w        (set_w),
      .fault_nonres (fault_nonres),
      .fault_ple    (fault_ple),
      .fault_ro     (fault_ro),
      .record_page  (record_page)
   );

   kt_relocate u_relocate (
      .cpu_va     (cpu_va),
      .par_value  (par_value),
      .map_enable (map_enable),
      .cpu_pa     (cpu_pa)
   );

   // register read mux, zero while no read is strobed
   always_comb
   begin
      reg_rdata = 16'h0000;
      if (reg_rd)
      begin
         case (reg_addr[7:6])
            kt_mmu_pkg::reg_sel_pdr: reg_rdata = reg_pdr_rdata;
            kt_mmu_pkg::reg_sel_par: reg_rdata = reg_par_rdata;
            kt_mmu_pkg::reg_sel_mmr: reg_rdata = reg_mmr_rdata;
            default:                 reg_rdata = 16'h0000;
         endcase
      end
   end

endmodule

// ==== kt_mmu_asserts.sv ====
/*
 * KT-11 MMU properties: unmapped translation, quiet abort/trap lines
 * and the mmr0/mmr2 freeze
 */
`timescale 1ns/100ps

module kt_mmu_asserts
(
   input logic        clk,
   input logic        local_reset,
   input logic [15:0] cpu_va,
   input logic        cpu_rd,
   input logic        cpu_wr,
   input logic [21:0] cpu_pa,
   input logic        signal_abort,
   input logic        signal_trap,
   input logic        reg_wr,
   input logic        mmu_on,
   input logic        map_enable,
   input logic        fault_frozen,
   input logic [15:0] mmr0,
   input logic [15:0] mmr2
);

   a_unmapped: assert property (@(posedge clk) disable iff (local_reset)
      !map_enable |-> cpu_pa == ((cpu_va[15:13] == 3'd7) ? {6'h3f, cpu_va} : {6'h00, cpu_va}))
      else $error("unmapped address does not follow the virtual address");

   a_quiet: assert property (@(posedge clk) disable iff (local_reset)
      (!mmu_on || !(cpu_rd || cpu_wr)) |-> (!signal_abort && !signal_trap))
      else $error("abort or trap without an access strobe or with the MMU off");

   a_mmr0_frozen: assert property (@(posedge clk) disable iff (local_reset)
      (fault_frozen && !reg_wr) |=> $stable(mmr0))
      else $error("frozen mmr0 changed without a register write");

   // mmr2 stops following fetches once a fault is held
   a_mmr2_frozen: assert property (@(posedge clk) disable iff (local_reset)
      fault_frozen |=> $stable(mmr2))
      else $error("mmr2 changed while mmr0 was frozen");

endmodule

bind kt_mmu kt_mmu_asserts u_asserts (
   .clk          (clk),
   .local_reset  (local_reset),
   .cpu_va       (cpu_va),
   .cpu_rd       (cpu_rd),
   .cpu_wr       (cpu_wr),
   .cpu_pa       (cpu_pa),
   .signal_abort (signal_abort),
   .signal_trap  (signal_trap),
   .reg_wr       (reg_wr),
   .mmu_on       (mmu_on),
   .map_enable   (map_enable),
   .fault_frozen (fault_frozen),
   .mmr0         (u_status_regs.mmr0),
   .mmr2         (u_status_regs.mmr2)
);

// ==== kt_mmu_pkg.sv ====
/*
 * KT-11 MMU shared constants: register masks, access-control codes,
 * CPU modes and register field positions for the 11/34 variant
 */
package kt_mmu_pkg;

   // pdr bits visible on read, acf low bit not implemented
   localparam logic [15:0] pdr_read_mask  = 16'o077716;
   localparam logic [7:0]  pdr_wr_mask_hi = 8'o177;
   localparam logic [7:0]  pdr_wr_mask_lo = 8'o016;
   localparam logic [15:0] par_mask       = 16'o007777;

   // access-control field codes
   localparam logic [2:0] acf_nonres     = 3'd0;
   localparam logic [2:0] acf_ro_trap    = 3'd1;
   localparam logic [2:0] acf_ro         = 3'd2;
   localparam logic [2:0] acf_unused3    = 3'd3;
   localparam logic [2:0] acf_rw_trap    = 3'd4;
   localparam logic [2:0] acf_rw_trap_wr = 3'd5;
   localparam logic [2:0] acf_rw         = 3'd6;
   localparam logic [2:0] acf_unused7    = 3'd7;

   localparam logic [1:0] mode_kernel = 2'b00;
   localparam logic [1:0] mode_super  = 2'b01;
   localparam logic [1:0] mode_user   = 2'b11;

   // pdr field positions
   localparam int pdr_a_bit  = 7;
   localparam int pdr_w_bit  = 6;
   localparam int pdr_ed_bit = 3;
   localparam int pdr_plf_hi = 14;
   localparam int pdr_plf_lo = 8;

   // mmr0 field positions
   localparam int mmr0_abort_nr_bit  = 15;
   localparam int mmr0_abort_ple_bit = 14;
   localparam int mmr0_abort_ro_bit  = 13;
   localparam int mmr0_maint_bit     = 8;
   localparam int mmr0_mode_hi       = 6;
   localparam int mmr0_mode_lo       = 5;
   localparam int mmr0_page_hi       = 3;
   localparam int mmr0_page_lo       = 1;
   localparam int mmr0_enable_bit    = 0;

   // mmr3 split i/d enables per mode
   localparam int mmr3_kernel_d_bit = 2;
   localparam int mmr3_super_d_bit  = 1;
   localparam int mmr3_user_d_bit   = 0;

   // register space selectors, address bits 7:6
   localparam logic [1:0] reg_sel_pdr = 2'b00;
   localparam logic [1:0] reg_sel_par = 2'b01;
   localparam logic [1:0] reg_sel_mmr = 2'b10;

   // status register number, address bits 1:0
   localparam logic [1:0] mmr_sel_mmr0 = 2'd0;
   localparam logic [1:0] mmr_sel_mmr1 = 2'd1;
   localparam logic [1:0] mmr_sel_mmr2 = 2'd2;
   localparam logic [1:0] mmr_sel_mmr3 = 2'd3;

endpackage

// ==== kt_page_regs.sv ====
/*
 * KT-11 page register file: 64 PAR/PDR pairs in byte halves, with
 * byte-enabled software writes and A/W bit updates from accesses
 */
`timescale 1ns/100ps

module kt_page_regs
(
   input  logic        clk,
   input  logic [1:0]  cpu_mode,
   input  logic        cpu_trap,
   input  logic        cpu_i_access,
   input  logic        d_space_enable,
   input  logic [2:0]  cpu_page,
   input  logic        reg_wr,
   input  logic [1:0]  reg_be,
   input  logic [7:0]  reg_addr,
   input  logic [15:0] reg_wdata,
   input  logic        update_pdr,
   input  logic        set_a,
   input  logic        set_w,
   output logic [15:0] pdr_value,
   output logic [15:0] par_value,
   output logic [15:0] reg_pdr_rdata,
   output logic [15:0] reg_par_rdata
);

   logic [7:0]  pdr_h [64];
   logic [7:0]  pdr_l [64];
   logic [7:0]  par_h [64];
   logic [7:0]  par_l [64];
   logic [5:0]  xlate_index;
   logic [5:0]  sw_index;
   logic [1:0]  index_mode;
   logic        index_d;
   logic [15:0] pdr_update_value;

   // trap vector fetches always use kernel space
   assign index_mode = cpu_trap ? kt_mmu_pkg::mode_kernel : cpu_mode;
   assign index_d    = d_space_enable & ~cpu_i_access;
   // index is {mode, d-space, page}, same layout as the register port
   assign xlate_index = {index_mode, index_d, cpu_page};
   assign sw_index    = reg_addr[5:0];

   assign pdr_value = {pdr_h[xlate_index], pdr_l[xlate_index]} & kt_mmu_pkg::pdr_read_mask;
   assign par_value = {par_h[xlate_index], par_l[xlate_index]} & kt_mmu_pkg::par_mask;

   assign reg_pdr_rdata = {pdr_h[sw_index], pdr_l[sw_index]} & kt_mmu_pkg::pdr_read_mask;
   assign reg_par_rdata = {par_h[sw_index], par_l[sw_index]} & kt_mmu_pkg::par_mask;

   always_comb
   begin
      pdr_update_value = pdr_value;
      if (set_a)
         pdr_update_value[kt_mmu_pkg::pdr_a_bit] = 1'b1;
      if (set_w)
         pdr_update_value[kt_mmu_pkg::pdr_w_bit] = 1'b1;
   end

   // software writes win over access updates
   always_ff @(posedge clk)
   begin
      if (reg_wr)
      begin
         if (reg_addr[7:6] == kt_mmu_pkg::reg_sel_pdr)
         begin
            if (reg_be[1])
               pdr_h[sw_index] <= reg_wdata[15:8] & kt_mmu_pkg::pdr_wr_mask_hi;
            if (reg_be[0])
               pdr_l[sw_index] <= reg_wdata[7:0] & kt_mmu_pkg::pdr_wr_mask_lo;
         end
         else if (reg_addr[7:6] == kt_mmu_pkg::reg_sel_par)
         begin
            if (reg_be[1])
               par_h[sw_index] <= reg_wdata[15:8];
            if (reg_be[0])
               par_l[sw_index] <= reg_wdata[7:0];
         end
      end
      else if (update_pdr)
      begin
         pdr_h[xlate_index] <= pdr_update_value[15:8];
         pdr_l[xlate_index] <= pdr_update_value[7:0];
      end
   end

endmodule

// ==== kt_relocate.sv ====
/*
 * KT-11 relocation: 16-bit virtual to 18-bit physical address,
 * presented on 22 bits with the I/O page at the top
 */
`timescale 1ns/100ps

module kt_relocate
(
   input  logic [15:0] cpu_va,
   input  logic [15:0] par_value,
   input  logic        map_enable,
   output logic [21:0] cpu_pa
);

   logic [17:0] map_sum;
   logic [21:0] mapped_pa;
   logic [21:0] unmapped_pa;
   logic        va_is_iopage;
   logic        pa_is_iopage;

   // par counts 64-byte blocks
   assign map_sum = {par_value[11:0], 6'b000000} + {5'b00000, cpu_va[12:0]};

   // top 8 KB of the 18-bit space is the I/O page
   assign pa_is_iopage = (map_sum[17:13] == 5'b11111);
   assign mapped_pa    = pa_is_iopage ? {6'o77, map_sum[15:0]} : {4'b0000, map_sum};

   assign va_is_iopage = (cpu_va[15:13] == 3'b111);
   assign unmapped_pa  = va_is_iopage ? {6'o77, cpu_va} : {6'o00, cpu_va};

   assign cpu_pa = map_enable ? mapped_pa : unmapped_pa;

endmodule

// ==== kt_status_regs.sv ====
/*
 * KT-11 status registers: mmr0 with first-fault freeze, mmr2 fetch
 * address tracking and mmr3 split I/D enables
 */
`timescale 1ns/100ps

module kt_status_regs
(
   input  logic        clk,
   input  logic        local_reset,
   input  logic        reg_wr,
   input  logic [1:0]  reg_be,
   input  logic [7:0]  reg_addr,
   input  logic [15:0] reg_wdata,
   input  logic [15:0] cpu_va,
   input  logic [1:0]  cpu_mode,
   input  logic        cpu_d_access,
   input  logic        fetch_va,
   input  logic        fault_nonres,
   input  logic        fault_ple,
   input  logic        fault_ro,
   input  logic        record_page,
   output logic        mmu_on,
   output logic        map_enable,
   output logic        d_space_enable,
   output logic        fault_frozen,
   output logic [15:0] reg_mmr_rdata
);

   logic [15:0] mmr0;
   logic [15:0] mmr2;
   logic [15:0] mmr3;
   logic [15:0] mmr0_rec;
   logic [15:0] mmr0_live;
   logic        maint_mode;
   logic        mmr_sel;

   assign mmu_on       = mmr0[kt_mmu_pkg::mmr0_enable_bit];
   assign maint_mode   = mmr0[kt_mmu_pkg::mmr0_maint_bit];
   assign fault_frozen = mmr0[kt_mmu_pkg::mmr0_abort_nr_bit] |
                         mmr0[kt_mmu_pkg::mmr0_abort_ple_bit] |
                         mmr0[kt_mmu_pkg::mmr0_abort_ro_bit];
   // maintenance mode maps destination accesses only
   assign map_enable   = mmu_on | (maint_mode & cpu_d_access);
   assign mmr_sel      = (reg_addr[7:6] == kt_mmu_pkg::reg_sel_mmr);

   always_comb
   begin
      case (cpu_mode)
         kt_mmu_pkg::mode_kernel: d_space_enable = mmr3[kt_mmu_pkg::mmr3_kernel_d_bit];
         kt_mmu_pkg::mode_super:  d_space_enable = mmr3[kt_mmu_pkg::mmr3_super_d_bit];
         kt_mmu_pkg::mode_user:   d_space_enable = mmr3[kt_mmu_pkg::mmr3_user_d_bit];
         default:                 d_space_enable = 1'b0;
      endcase
   end

   always_comb
   begin
      mmr0_rec = mmr0;
      if (fault_nonres)
         mmr0_rec[kt_mmu_pkg::mmr0_abort_nr_bit] = 1'b1;
      if (fault_ple)
         mmr0_rec[kt_mmu_pkg::mmr0_abort_ple_bit] = 1'b1;
      if (fault_ro)
         mmr0_rec[kt_mmu_pkg::mmr0_abort_ro_bit] = 1'b1;
      if (record_page)
      begin
         mmr0_rec[kt_mmu_pkg::mmr0_mode_hi:kt_mmu_pkg::mmr0_mode_lo] = cpu_mode;
         mmr0_rec[kt_mmu_pkg::mmr0_page_hi:kt_mmu_pkg::mmr0_page_lo] = cpu_va[15:13];
      end
   end

   // live view shows the current mode and page until a fault latches
   always_comb
   begin
      mmr0_live = mmr0;
      if (!fault_frozen && mmu_on)
      begin
         mmr0_live[kt_mmu_pkg::mmr0_mode_hi:kt_mmu_pkg::mmr0_mode_lo] = cpu_mode;
         mmr0_live[kt_mmu_pkg::mmr0_page_hi:kt_mmu_pkg::mmr0_page_lo] = cpu_va[15:13];
      end
   end

   always_comb
   begin
      case (reg_addr[1:0])
         kt_mmu_pkg::mmr_sel_mmr0: reg_mmr_rdata = mmr0_live;
         kt_mmu_pkg::mmr_sel_mmr1: reg_mmr_rdata = 16'h0000;
         kt_mmu_pkg::mmr_sel_mmr2: reg_mmr_rdata = mmr2;
         default:                  reg_mmr_rdata = mmr3;
      endcase
   end

   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
      begin
         mmr0 <= 16'h0000;
         mmr3 <= 16'h0000;
      end
      else if (reg_wr)
      begin
         if (mmr_sel && reg_addr[1:0] == kt_mmu_pkg::mmr_sel_mmr0)
         begin
            if (reg_be[1])
               mmr0[15:8] <= reg_wdata[15:8];
            if (reg_be[0])
               mmr0[7:0] <= reg_wdata[7:0];
         end
         else if (mmr_sel && reg_addr[1:0] == kt_mmu_pkg::mmr_sel_mmr3)
         begin
            if (reg_be[1])
               mmr3[15:8] <= reg_wdata[15:8];
            if (reg_be[0])
               mmr3[7:0] <= reg_wdata[7:0];
         end
      end
      else if (!fault_frozen)
         mmr0 <= mmr0_rec;
   end

   // fetch address tracking stops once a fault is latched
   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
         mmr2 <= 16'h0000;
      else if (fetch_va && !fault_frozen && cpu_mode != kt_mmu_pkg::mode_super)
         mmr2 <= cpu_va;
   end

endmodule

// ==== run.sh ====
#!/bin/bash
# build and run the MMU testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tb_kt_mmu -o sim_kt_mmu &&
./obj_dir/sim_kt_mmu | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== src.f ====
kt_mmu_pkg.sv
kt_page_regs.sv
kt_access_check.sv
kt_status_regs.sv
kt_relocate.sv
kt_mmu.sv
kt_mmu_asserts.sv
tb_kt_mmu.sv

// ==== tb_kt_mmu.sv ====
/*
 * Testbench for the KT-11 MMU covering register round trips, unmapped and
 * mapped translation, access control, fault freeze and mmr2 tracking
 */
`timescale 1ns/100ps

module tb_kt_mmu;

   logic        clk;
   logic        local_reset;
   logic [15:0] cpu_va;
   logic [1:0]  cpu_mode;
   logic        cpu_rd;
   logic        cpu_wr;
   logic        cpu_i_access;
   logic        cpu_d_access;
   logic        cpu_trap;
   logic        fetch_va;
   logic        trap_odd;
   logic [21:0] cpu_pa;
   logic        signal_abort;
   logic        signal_trap;
   logic        reg_wr;
   logic        reg_rd;
   logic [1:0]  reg_be;
   logic [7:0]  reg_addr;
   logic [15:0] reg_wdata;
   logic [15:0] reg_rdata;

   // shadow copies of what software wrote plus access side effects
   logic [15:0] pdr_sh [64];
   logic [15:0] par_sh [64];
   logic [15:0] mmr0_sh;
   logic [15:0] mmr2_sh;
   logic [15:0] mmr3_sh;

   kt_mmu u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   // twice the roughly 1000 cycles that the tests take
   initial
   begin
      #(2000 * 100);
      $display("watchdog expired, the tests did not finish within 2000 cycles");
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
   end

   task automatic fail(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
   endtask

   task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
         fail($sformatf("%s is %0h, expected %0h", what, got, exp));
   endtask

   // inputs change 10 ns after the edge and idle unless the caller drives them
   task automatic next_cycle;
      @(posedge clk);
      #10;
      cpu_rd       = 1'b0;
      cpu_wr       = 1'b0;
      fetch_va     = 1'b0;
      cpu_va       = 16'h0000;
      cpu_mode     = kt_mmu_pkg::mode_kernel;
      cpu_i_access = 1'b0;
      cpu_d_access = 1'b0;
      trap_odd     = 1'b0;
      reg_wr       = 1'b0;
      reg_rd       = 1'b0;
   endtask

   function automatic logic [15:0] expected_read(input logic [7:0] addr);
      logic [15:0] v;
      case (addr[7:6])
         kt_mmu_pkg::reg_sel_pdr: v = pdr_sh[addr[5:0]] & kt_mmu_pkg::pdr_read_mask;
         kt_mmu_pkg::reg_sel_par: v = par_sh[addr[5:0]] & kt_mmu_pkg::par_mask;
         kt_mmu_pkg::reg_sel_mmr:
         begin
            case (addr[1:0])
               2'd0:
               begin
                  v = mmr0_sh;
                  // live view shows the idle cpu in kernel mode on page 0
                  if (mmr0_sh[15:13] == 3'b000 && mmr0_sh[0])
                  begin
                     v[6:5] = 2'b00;
                     v[3:1] = 3'b000;
                  end
               end
               2'd1: v = 16'h0000;
               2'd2: v = mmr2_sh;
               default: v = mmr3_sh;
            endcase
         end
         default: v = 16'h0000;
      endcase
      return v;
   endfunction

   task automatic reg_write(input logic [7:0] addr, input logic [1:0] be, input logic [15:0] data);
      next_cycle();
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_be    = be;
      reg_wdata = data;
      if (addr[7:6] == kt_mmu_pkg::reg_sel_pdr)
      begin
         if (be[1])
            pdr_sh[addr[5:0]][15:8] = data[15:8] & kt_mmu_pkg::pdr_wr_mask_hi;
         if (be[0])
            pdr_sh[addr[5:0]][7:0] = data[7:0] & kt_mmu_pkg::pdr_wr_mask_lo;
      end
      else if (addr[7:6] == kt_mmu_pkg::reg_sel_par)
      begin
         if (be[1])
            par_sh[addr[5:0]][15:8] = data[15:8];
         if (be[0])
            par_sh[addr[5:0]][7:0] = data[7:0];
      end
      else if (addr[7:6] == kt_mmu_pkg::reg_sel_mmr && addr[1:0] == 2'd0)
      begin
         if (be[1])
            mmr0_sh[15:8] = data[15:8];
         if (be[0])
            mmr0_sh[7:0] = data[7:0];
      end
      else if (addr[7:6] == kt_mmu_pkg::reg_sel_mmr && addr[1:0] == 2'd3)
      begin
         if (be[1])
            mmr3_sh[15:8] = data[15:8];
         if (be[0])
            mmr3_sh[7:0] = data[7:0];
      end
   endtask

   task automatic reg_check(input logic [7:0] addr);
      next_cycle();
      reg_rd   = 1'b1;
      reg_addr = addr;
      #80;
      expect_eq(32'(reg_rdata), 32'(expected_read(addr)), $sformatf("register %0h", addr));
   endtask

   // result bits from msb are abort, trap, set a, set w, nonres, length, read-only and record
   function automatic logic [7:0] decode(input logic [15:0] pdr, input logic [15:0] va,
                                         input logic [1:0] mode, input logic wr,
                                         input logic todd);
      logic       err;
      logic [7:0] r;
      r   = 8'h00;
      err = pdr[3] ? (va[12:6] < pdr[14:8]) : (va[12:6] > pdr[14:8]);
      if (mode == kt_mmu_pkg::mode_super)
         r = 8'b1000_1001;
      else
      begin
         case (pdr[2:0])
            3'd0, 3'd3, 3'd7: r = {1'b1, 3'b000, 1'b1, err, 1'b0, 1'b1};
            3'd1, 3'd2:
            begin
               if (wr)
                  r = {1'b1, 3'b000, 1'b0, err, 2'b11};
               else if (pdr[2:0] == 3'd2)
                  r = {err, 4'b0000, err, 1'b0, 1'b1};
            end
            3'd4: r = 8'b0110_1001;
            3'd5: r = wr ? 8'h00 : {err, 4'b0000, err, 1'b0, 1'b1};
            default:
               r = wr ? {1'b0, err, 1'b0, ~todd, 1'b0, err, 1'b0, 1'b1}
                      : {err, 4'b0000, err, 1'b0, 1'b1};
         endcase
      end
      return r;
   endfunction

   task automatic access(input logic [15:0] va, input logic [1:0] mode, input logic wr,
                         input logic i_acc, input logic todd, input logic fetch);
      logic        d;
      logic [5:0]  idx;
      logic [15:0] pdr;
      logic [15:0] par;
      logic [17:0] sum;
      logic [21:0] pa;
      logic [7:0]  r;
      logic        frozen;
      next_cycle();
      cpu_va       = va;
      cpu_mode     = mode;
      cpu_rd       = ~wr;
      cpu_wr       = wr;
      cpu_i_access = i_acc;
      cpu_d_access = ~i_acc;
      trap_odd     = todd;
      fetch_va     = fetch;
      d   = (mode == 2'b00) ? mmr3_sh[2] : (mode == 2'b01) ? mmr3_sh[1] : mmr3_sh[0];
      idx = {mode, d & ~i_acc, va[15:13]};
      pdr = pdr_sh[idx] & kt_mmu_pkg::pdr_read_mask;
      par = par_sh[idx] & kt_mmu_pkg::par_mask;
      sum = {par[11:0], 6'b000000} + {5'b00000, va[12:0]};
      if (mmr0_sh[0] || (mmr0_sh[8] && !i_acc))
         pa = (sum[17:13] == 5'h1f) ? {6'h3f, sum[15:0]} : {4'h0, sum};
      else
         pa = (va[15:13] == 3'd7) ? {6'h3f, va} : {6'h00, va};
      r = mmr0_sh[0] ? decode(pdr, va, mode, wr, todd) : 8'h00;
      #80;
      expect_eq(32'(cpu_pa), 32'(pa), "cpu_pa");
      expect_eq(32'(signal_abort), 32'(r[7]), "signal_abort");
      expect_eq(32'(signal_trap), 32'(r[6]), "signal_trap");
      pdr_sh[idx][7] = pdr_sh[idx][7] | r[5];
      pdr_sh[idx][6] = pdr_sh[idx][6] | r[4];
      frozen = |mmr0_sh[15:13];
      if (fetch && !frozen && mode != kt_mmu_pkg::mode_super)
         mmr2_sh = va;
      if (!frozen)
      begin
         mmr0_sh[15:13] = mmr0_sh[15:13] | r[3:1];
         if (r[0])
         begin
            mmr0_sh[6:5] = mode;
            mmr0_sh[3:1] = va[15:13];
         end
      end
   endtask

   function automatic logic [1:0] random_mode;
      return ($urandom % 2 == 0) ? kt_mmu_pkg::mode_kernel : kt_mmu_pkg::mode_user;
   endfunction

   initial
   begin
      logic [6:0] blk;
      void'($urandom(4));
      local_reset  = 1'b1;
      cpu_va       = 16'h0000;
      cpu_mode     = 2'b00;
      cpu_rd       = 1'b0;
      cpu_wr       = 1'b0;
      cpu_i_access = 1'b0;
      cpu_d_access = 1'b0;
      cpu_trap     = 1'b0;
      fetch_va     = 1'b0;
      trap_odd     = 1'b0;
      reg_wr       = 1'b0;
      reg_rd       = 1'b0;
      reg_be       = 2'b00;
      reg_addr     = 8'h00;
      reg_wdata    = 16'h0000;
      mmr0_sh      = 16'h0000;
      mmr2_sh      = 16'h0000;
      mmr3_sh      = 16'h0000;
      repeat (2)
         @(posedge clk);
      #10;
      local_reset = 1'b0;

      // register round trip after a full init so no byte stays unknown
      for (int i = 0; i < 128; i++)
         reg_write(i[7:0], 2'b11, 16'($urandom));
      for (int i = 0; i < 128; i++)
      begin
         reg_write(i[7:0], i[1:0], 16'($urandom));
         reg_check(i[7:0]);
      end
      for (int i = 0; i < 8; i++)
      begin
         reg_write(8'h80, i[1:0], 16'($urandom));
         reg_check(8'h80);
         reg_write(8'h83, i[1:0], 16'($urandom));
         reg_check(8'h83);
      end
      reg_check(8'h81);
      reg_write(8'h80, 2'b11, 16'h0000);
      reg_write(8'h83, 2'b11, 16'h0000);

      // unmapped addressing with the mmu off
      for (int i = 0; i < 40; i++)
         access(16'($urandom), random_mode(), 1'($urandom), 1'($urandom), 1'b0, 1'($urandom));
      reg_check(8'h82);

      // mapped addressing with split i/d for kernel and user in the first half
      reg_write(8'h83, 2'b11, 16'h0005);
      reg_write(8'h80, 2'b11, 16'h0001);
      for (int i = 0; i < 100; i++)
      begin
         if (i == 50)
            reg_write(8'h83, 2'b11, 16'h0000);
         if (i % 10 == 0)
            reg_write(8'h80, 2'b11, 16'h0001);
         access(16'($urandom), random_mode(), 1'($urandom), 1'($urandom), 1'($urandom), 1'b0);
         reg_check(8'h80);
      end

      // access control sweep on user page 3 with length 40
      for (int c = 0; c < 32; c++)
      begin
         for (int out = 0; out < 2; out++)
         begin
            reg_write(8'h80, 2'b11, 16'h0001);
            reg_write(8'h33, 2'b11, {1'b0, 7'd40, 4'b0000, c[3], c[2:0]});
            blk = ((out == 1) != c[3]) ? 7'd60 : 7'd20;
            access({3'd3, blk, 6'($urandom)}, kt_mmu_pkg::mode_user, c[4], 1'b0,
                   1'($urandom), 1'b0);
            reg_check(8'h33);
            reg_check(8'h80);
         end
      end

      // fault freeze and re-arm
      reg_write(8'h32, 2'b11, 16'h0000);
      reg_write(8'h80, 2'b11, 16'h0001);
      access(16'o120000, kt_mmu_pkg::mode_super, 1'b0, 1'b0, 1'b0, 1'b0);
      reg_check(8'h80);
      access(16'o040000, kt_mmu_pkg::mode_user, 1'b1, 1'b0, 1'b0, 1'b0);
      reg_check(8'h80);
      reg_write(8'h80, 2'b11, 16'h0001);
      access(16'o040100, kt_mmu_pkg::mode_user, 1'b0, 1'b0, 1'b0, 1'b0);
      reg_check(8'h80);

      // mmr2 follows fetches until a fault freezes mmr0
      for (int p = 0; p < 8; p++)
         reg_write({5'b00110, p[2:0]}, 2'b11, 16'h7f06);
      reg_write(8'h80, 2'b11, 16'h0001);
      for (int i = 0; i < 15; i++)
      begin
         if (i == 10)
            access(16'($urandom), kt_mmu_pkg::mode_super, 1'b0, 1'b1, 1'b0, 1'b1);
         access(16'($urandom), kt_mmu_pkg::mode_user, 1'b0, 1'b1, 1'b0, 1'b1);
         reg_check(8'h82);
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule
